// ==== pc_harden_pkg.sv ====
// Shared widths, increments and register map; all widths are fixed here and are not parameters
package pc_harden_pkg;

  // Program counter width
  localparam int PC_W = 32;

  // Linear step for a full-size instruction
  localparam logic [PC_W-1:0] INSTR_INC = 32'd4;

  // Linear step for a compressed instruction
  localparam logic [PC_W-1:0] INSTR_INC_CMPR = 32'd2;

  // Wishbone word address and data widths
  localparam int WB_ADR_W = 2;
  localparam int WB_DAT_W = 32;

  // Register word addresses
  // Address 3 is unmapped and reads as zero
  localparam logic [WB_ADR_W-1:0] REG_CTRL = 2'd0;
  localparam logic [WB_ADR_W-1:0] REG_STATUS = 2'd1;
  localparam logic [WB_ADR_W-1:0] REG_FAULT_CNT = 2'd2;

  // Saturating fault counter width
  localparam int FAULT_CNT_W = 16;

  // Redirect source presented together with pc_set
  // Only jump, mret and branch targets are double-checked
  typedef enum logic [2:0] {
    PC_BOOT   = 3'd0,
    PC_JUMP   = 3'd1,
    PC_MRET   = 3'd2,
    PC_BRANCH = 3'd3,
    PC_TRAP   = 3'd4
  } pc_mux_e;

endpackage

// ==== pc_seq_check.sv ====
// Checks linear IF PC against the last handed-off ID PC; handoffs with ptr_in_if or a pc_set are not checked
`timescale 1ns/10ps

module pc_seq_check
  import pc_harden_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_n,
  input  logic            if_valid,
  input  logic            id_ready,
  input  logic [PC_W-1:0] if_pc,
  input  logic            if_instr_cmpr,
  input  logic            dummy_insert,
  input  logic            ptr_in_if,
  input  logic            pc_set,
  input  logic            hardening_en,
  output logic            seq_fault
);

  // ID-stage copy of the previous handoff
  logic [PC_W-1:0] id_pc;
  logic            id_cmpr;
  logic            id_dummy;

  // Control state
  logic            armed;
  logic            redir_seen;

  logic            handoff;
  logic            check_en;
  logic [PC_W-1:0] pc_step;
  logic [PC_W-1:0] pc_expected;

  // IF to ID transfer on this edge
  assign handoff = if_valid && id_ready;

  // A redirect in this cycle also counts
  assign check_en = handoff && armed && !redir_seen && !pc_set && !ptr_in_if;

  // Dummy repeats the same PC, compressed steps by 2
  always_comb begin
    if (id_dummy) begin
      pc_step = '0;
    end else if (id_cmpr) begin
      pc_step = INSTR_INC_CMPR;
    end else begin
      pc_step = INSTR_INC;
    end
  end

  assign pc_expected = id_pc + pc_step;

  // Payload of the handed-off instruction
  always_ff @(posedge clk_i) begin
    if (handoff) begin
      id_pc    <= if_pc;
      id_cmpr  <= if_instr_cmpr;
      id_dummy <= dummy_insert;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      armed      <= 1'b0;
      redir_seen <= 1'b0;
      seq_fault  <= 1'b0;
    end else begin
      // First handoff arms the check
      if (handoff) begin
        armed <= 1'b1;
      end
      // Cleared at each handoff, a redirect in the handoff cycle still sticks
      if (handoff) begin
        redir_seen <= pc_set;
      end else if (pc_set) begin
        redir_seen <= 1'b1;
      end
      // One-cycle pulse after the offending handoff
      seq_fault <= check_en && hardening_en && (if_pc != pc_expected);
    end
  end

endmodule

// ==== pc_target_check.sv ====
// Compares jump, mret and branch targets over two presentations; trap and boot redirects are ignored
`timescale 1ns/10ps

module pc_target_check
  import pc_harden_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_n,
  input  logic            pc_set,
  input  pc_mux_e         pc_mux,
  input  logic            jump_in_id,
  input  logic            kill_id,
  input  logic            halt_id,
  input  logic            branch_in_ex,
  input  logic            kill_ex,
  input  logic            halt_ex,
  input  logic [PC_W-1:0] jump_target,
  input  logic [PC_W-1:0] mepc,
  input  logic [PC_W-1:0] branch_target,
  input  logic            branch_decision,
  input  logic            hardening_en,
  input  logic            dataindtiming_en,
  output logic            tgt_fault
);

  // Captured first presentation
  logic [PC_W-1:0] cap_target;
  logic            cap_decision;
  pc_mux_e         cap_src;
  logic            cap_valid;

  logic            id_live;
  logic            ex_live;
  logic            first_cycle;
  logic [PC_W-1:0] sel_target;
  logic [PC_W-1:0] live_target;
  logic            stage_live;
  logic            mismatch;

  // Stage still owns an instruction that is neither killed nor halted
  assign id_live = jump_in_id && !kill_id && !halt_id;
  assign ex_live = branch_in_ex && !kill_ex && !halt_ex;

  // Target chosen by the core for the first presentation
  always_comb begin
    sel_target  = '0;
    first_cycle = 1'b0;
    case (pc_mux)
      PC_JUMP: begin
        sel_target  = jump_target;
        first_cycle = pc_set && id_live;
      end
      PC_MRET: begin
        sel_target  = mepc;
        first_cycle = pc_set && id_live;
      end
      PC_BRANCH: begin
        sel_target  = branch_target;
        first_cycle = pc_set && ex_live;
      end
      default: begin
        sel_target  = '0;
        first_cycle = 1'b0;
      end
    endcase
  end

  // Live value and stage ownership for the captured source
  always_comb begin
    case (cap_src)
      PC_MRET: begin
        live_target = mepc;
        stage_live  = id_live;
      end
      PC_BRANCH: begin
        live_target = branch_target;
        stage_live  = ex_live;
      end
      default: begin
        live_target = jump_target;
        stage_live  = id_live;
      end
    endcase
  end

  // Decision is only compared when timing is data dependent
  assign mismatch = (live_target != cap_target) ||
                    ((cap_src == PC_BRANCH) && !dataindtiming_en &&
                     (branch_decision != cap_decision));

  always_ff @(posedge clk_i) begin
    if (first_cycle) begin
      cap_target   <= sel_target;
      cap_decision <= branch_decision;
      cap_src      <= pc_mux;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      cap_valid <= 1'b0;
      tgt_fault <= 1'b0;
    end else begin
      // Capture lives for exactly one following cycle
      cap_valid <= first_cycle;
      // Kill or halt in the second cycle drops the check
      tgt_fault <= cap_valid && stage_live && hardening_en && mismatch;
    end
  end

endmodule

// ==== pc_alert_csr.sv ====
// Wishbone classic slave with one-cycle ack; master must drop stb after ack, FAULT_CNT is read-only
`timescale 1ns/10ps

module pc_alert_csr
  import pc_harden_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_n,
  input  logic                wb_cyc,
  input  logic                wb_stb,
  input  logic                wb_we,
  input  logic [WB_ADR_W-1:0] wb_adr,
  input  logic [WB_DAT_W-1:0] wb_dat_w,
  input  logic                seq_fault,
  input  logic                tgt_fault,
  output logic [WB_DAT_W-1:0] wb_dat_r,
  output logic                wb_ack,
  output logic                hardening_en,
  output logic                dataindtiming_en,
  output logic                alert_major
);

  logic [1:0]             status;
  logic [FAULT_CNT_W-1:0] fault_cnt;

  logic                   access;
  logic                   wr_ctrl;
  logic                   wr_status;
  logic [1:0]             status_clr;
  logic [1:0]             status_set;
  logic                   any_fault;
  logic [WB_DAT_W-1:0]    rd_data;

  // New access only while ack is low
  assign access = wb_cyc && wb_stb && !wb_ack;

  assign wr_ctrl   = access && wb_we && (wb_adr == REG_CTRL);
  assign wr_status = access && wb_we && (wb_adr == REG_STATUS);

  // Write-1-to-clear mask
  assign status_clr = wr_status ? wb_dat_w[1:0] : 2'b00;
  assign status_set = {tgt_fault, seq_fault};

  // Both pulses in one cycle count once
  assign any_fault = seq_fault || tgt_fault;

  // Major alert follows the pulses directly
  assign alert_major = any_fault;

  // Read mux
  always_comb begin
    case (wb_adr)
      REG_CTRL:      rd_data = {{(WB_DAT_W-2){1'b0}}, dataindtiming_en, hardening_en};
      REG_STATUS:    rd_data = {{(WB_DAT_W-2){1'b0}}, status};
      REG_FAULT_CNT: rd_data = {{(WB_DAT_W-FAULT_CNT_W){1'b0}}, fault_cnt};
      default:       rd_data = '0;
    endcase
  end

  // Bus handshake
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= access;
    end
  end

  // Read data sampled with the access, held while ack is high
  always_ff @(posedge clk_i) begin
    if (access && !wb_we) begin
      wb_dat_r <= rd_data;
    end
  end

  // Enable bits, hardening on by default
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      hardening_en     <= 1'b1;
      dataindtiming_en <= 1'b0;
    end else if (wr_ctrl) begin
      hardening_en     <= wb_dat_w[0];
      dataindtiming_en <= wb_dat_w[1];
    end
  end

  // Sticky status, a fault set beats a clear in the same cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      status <= 2'b00;
    end else begin
      status <= (status & ~status_clr) | status_set;
    end
  end

  // Saturating fault counter
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      fault_cnt <= '0;
    end else if (any_fault && (fault_cnt != {FAULT_CNT_W{1'b1}})) begin
      fault_cnt <= fault_cnt + 1'b1;
    end
  end

endmodule

// ==== pc_harden_top.sv ====
// PC hardening monitor top; the core is external and the monitor never stalls it
`timescale 1ns/10ps

module pc_harden_top
  import pc_harden_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_n,
  // IF to ID handoff
  input  logic                if_valid,
  input  logic                id_ready,
  input  logic [PC_W-1:0]     if_pc,
  input  logic                if_instr_cmpr,
  input  logic                dummy_insert,
  input  logic                ptr_in_if,
  // Redirect control
  input  logic                pc_set,
  input  pc_mux_e             pc_mux,
  input  logic                jump_in_id,
  input  logic                kill_id,
  input  logic                halt_id,
  input  logic                branch_in_ex,
  input  logic                kill_ex,
  input  logic                halt_ex,
  input  logic [PC_W-1:0]     jump_target,
  input  logic [PC_W-1:0]     mepc,
  input  logic [PC_W-1:0]     branch_target,
  input  logic                branch_decision,
  // Wishbone slave
  input  logic                wb_cyc,
  input  logic                wb_stb,
  input  logic                wb_we,
  input  logic [WB_ADR_W-1:0] wb_adr,
  input  logic [WB_DAT_W-1:0] wb_dat_w,
  output logic [WB_DAT_W-1:0] wb_dat_r,
  output logic                wb_ack,
  output logic                alert_major
);

  logic hardening_en;
  logic dataindtiming_en;
  logic seq_fault;
  logic tgt_fault;

  // Linear PC increment check
  pc_seq_check u_seq_check (
    .clk_i         (clk_i),
    .rst_n         (rst_n),
    .if_valid      (if_valid),
    .id_ready      (id_ready),
    .if_pc         (if_pc),
    .if_instr_cmpr (if_instr_cmpr),
    .dummy_insert  (dummy_insert),
    .ptr_in_if     (ptr_in_if),
    .pc_set        (pc_set),
    .hardening_en  (hardening_en),
    .seq_fault     (seq_fault)
  );

  // Redirect target double check
  pc_target_check u_target_check (
    .clk_i            (clk_i),
    .rst_n            (rst_n),
    .pc_set           (pc_set),
    .pc_mux           (pc_mux),
    .jump_in_id       (jump_in_id),
    .kill_id          (kill_id),
    .halt_id          (halt_id),
    .branch_in_ex     (branch_in_ex),
    .kill_ex          (kill_ex),
    .halt_ex          (halt_ex),
    .jump_target      (jump_target),
    .mepc             (mepc),
    .branch_target    (branch_target),
    .branch_decision  (branch_decision),
    .hardening_en     (hardening_en),
    .dataindtiming_en (dataindtiming_en),
    .tgt_fault        (tgt_fault)
  );

  // Enables, status and alert
  pc_alert_csr u_alert_csr (
    .clk_i            (clk_i),
    .rst_n            (rst_n),
    .wb_cyc           (wb_cyc),
    .wb_stb           (wb_stb),
    .wb_we            (wb_we),
    .wb_adr           (wb_adr),
    .wb_dat_w         (wb_dat_w),
    .seq_fault        (seq_fault),
    .tgt_fault        (tgt_fault),
    .wb_dat_r         (wb_dat_r),
    .wb_ack           (wb_ack),
    .hardening_en     (hardening_en),
    .dataindtiming_en (dataindtiming_en),
    .alert_major      (alert_major)
  );

endmodule

// ==== tb_pc_harden.sv ====
// Table-driven testbench; expected alerts assume CTRL is only written between table segments
`timescale 1ns/10ps

module tb_pc_harden
  import pc_harden_pkg::*;
();

  // Bus accesses issued by the test sequence, used for the cycle limit
  localparam int WB_ACCESSES = 14;

  // One core-side cycle plus the expected fault with bit 0 sequential and bit 1 target
  typedef struct packed {
    logic            valid;
    logic            ready;
    logic [PC_W-1:0] pc;
    logic            cmpr;
    logic            dummy;
    logic            ptr;
    logic            pc_set;
    pc_mux_e         mux;
    logic            jump_in_id;
    logic            kill_id;
    logic            halt_id;
    logic            branch_in_ex;
    logic            kill_ex;
    logic            halt_ex;
    logic [PC_W-1:0] jt;
    logic [PC_W-1:0] mepc;
    logic [PC_W-1:0] bt;
    logic            bdec;
    logic [1:0]      code;
  } row_t;

  logic                clk_i;
  logic                rst_n;
  logic                if_valid;
  logic                id_ready;
  logic                if_instr_cmpr;
  logic                dummy_insert;
  logic                ptr_in_if;
  logic                pc_set;
  logic                jump_in_id;
  logic                kill_id;
  logic                halt_id;
  logic                branch_in_ex;
  logic                kill_ex;
  logic                halt_ex;
  logic                branch_decision;
  logic [PC_W-1:0]     if_pc;
  logic [PC_W-1:0]     jump_target;
  logic [PC_W-1:0]     mepc;
  logic [PC_W-1:0]     branch_target;
  pc_mux_e             pc_mux;
  logic                wb_cyc;
  logic                wb_stb;
  logic                wb_we;
  logic                wb_ack;
  logic                alert_major;
  logic [WB_ADR_W-1:0] wb_adr;
  logic [WB_DAT_W-1:0] wb_dat_w;
  logic [WB_DAT_W-1:0] wb_dat_r;

  row_t rows[$];
  int seg_end[4];
  int cycle_cnt = 0;
  int cycle_limit = 1000;
  // Model of the sticky status and the fault counter
  logic [1:0] model_status;
  logic [FAULT_CNT_W-1:0] model_cnt;
  logic [PC_W-1:0] base_lin;
  logic [PC_W-1:0] base_ptr;
  logic [PC_W-1:0] base_redir;
  logic [PC_W-1:0] base_off;
  logic [PC_W-1:0] tgt_a;
  logic [PC_W-1:0] tgt_b;

  pc_harden_top uut (.*);

  always #2 clk_i = ~clk_i;

  // Run limit
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("tests failed");
      $fatal(1);
    end
  end

  function automatic row_t idle_row();
    row_t r;
    r = '0;
    r.mux = PC_BOOT;
    return r;
  endfunction

  // IF to ID handoff in this cycle
  function automatic row_t handoff_row(input logic [PC_W-1:0] pc, input logic cmpr,
                                       input logic dummy, input logic ptr, input logic [1:0] code);
    row_t r;
    r = idle_row();
    r.valid = 1'b1;
    r.ready = 1'b1;
    r.pc = pc;
    r.cmpr = cmpr;
    r.dummy = dummy;
    r.ptr = ptr;
    r.code = code;
    return r;
  endfunction

  // One presentation of a redirect with pc_set only on the first
  function automatic row_t redirect_row(input logic first, input pc_mux_e src,
                                        input logic [PC_W-1:0] tgt, input logic dec,
                                        input logic kill, input logic halt, input logic [1:0] code);
    row_t r;
    r = idle_row();
    r.pc_set = first;
    r.mux = src;
    r.bdec = dec;
    r.code = code;
    if (src == PC_BRANCH) begin
      r.branch_in_ex = 1'b1;
      r.kill_ex = kill;
      r.halt_ex = halt;
      r.bt = tgt;
    end else begin
      r.jump_in_id = 1'b1;
      r.kill_id = kill;
      r.halt_id = halt;
      if (src == PC_MRET) r.mepc = tgt;
      else r.jt = tgt;
    end
    return r;
  endfunction

  // Two presentations and a gap with the expected fault on the second one
  task automatic add_redirect(input pc_mux_e src, input logic [PC_W-1:0] t1,
                              input logic [PC_W-1:0] t2, input logic d1, input logic d2,
                              input logic kill2, input logic halt2, input logic [1:0] code);
    rows.push_back(redirect_row(1'b1, src, t1, d1, 1'b0, 1'b0, 2'b00));
    rows.push_back(redirect_row(1'b0, src, t2, d2, kill2, halt2, code));
    rows.push_back(idle_row());
  endtask

  task automatic drive_row(input row_t r);
    if_valid        <= r.valid;
    id_ready        <= r.ready;
    if_pc           <= r.pc;
    if_instr_cmpr   <= r.cmpr;
    dummy_insert    <= r.dummy;
    ptr_in_if       <= r.ptr;
    pc_set          <= r.pc_set;
    pc_mux          <= r.mux;
    jump_in_id      <= r.jump_in_id;
    kill_id         <= r.kill_id;
    halt_id         <= r.halt_id;
    branch_in_ex    <= r.branch_in_ex;
    kill_ex         <= r.kill_ex;
    halt_ex         <= r.halt_ex;
    jump_target     <= r.jt;
    mepc            <= r.mepc;
    branch_target   <= r.bt;
    branch_decision <= r.bdec;
  endtask

  task automatic report_fail(input string msg);
    $display("Fail at %0t ns: %s", $time, msg);
    $display("tests failed");
    $fatal(1);
  endtask

  // Alert of a row is visible in the cycle after its edge
  task automatic check_alert(input int idx);
    logic exp_alert;
    exp_alert = |rows[idx].code;
    assert (alert_major == exp_alert)
      else report_fail($sformatf("row %0d alert_major %b expected %b",
                                 idx, alert_major, exp_alert));
    model_status = model_status | rows[idx].code;
    if (exp_alert) model_cnt = model_cnt + 16'd1;
  endtask

  task automatic apply_rows(input int first, input int last);
    int i;
    for (i = first; i < last; i++) begin
      @(posedge clk_i);
      drive_row(rows[i]);
      @(negedge clk_i);
      if (i > first) check_alert(i - 1);
    end
    @(posedge clk_i);
    drive_row(idle_row());
    @(negedge clk_i);
    check_alert(last - 1);
  endtask

  task automatic wb_access(input logic we, input logic [WB_ADR_W-1:0] adr,
                           input logic [WB_DAT_W-1:0] data);
    @(posedge clk_i);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= data;
    @(negedge clk_i);
    while (!wb_ack) @(negedge clk_i);
    // Read data is compared while ack is high
    if (!we) begin
      assert (wb_dat_r == data)
        else report_fail($sformatf("read addr %0d got %h expected %h", adr, wb_dat_r, data));
    end
    @(posedge clk_i);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
    // Ack lasts a single cycle
    @(negedge clk_i);
    assert (!wb_ack)
      else report_fail($sformatf("wb_ack %b expected 0 in the cycle after ack", wb_ack));
  endtask

  initial begin
    row_t r;
    void'($urandom(89751));
    clk_i = 1'b0;
    rst_n <= 1'b0;
    drive_row(idle_row());
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we <= 1'b0;
    wb_adr <= '0;
    wb_dat_w <= '0;
    model_status = 2'b00;
    model_cnt = '0;
    base_lin = $urandom() & 32'hFFFF_FFFC;
    base_ptr = $urandom() & 32'hFFFF_FFFC;
    base_redir = $urandom() & 32'hFFFF_FFFC;
    base_off = $urandom() & 32'hFFFF_FFFC;
    tgt_a = $urandom() & 32'hFFFF_FFFE;
    tgt_b = $urandom() & 32'hFFFF_FFFE;

    // Idle rows then a clean stream with 4 and 2 byte steps plus a dummy and a pointer handoff
    repeat (3) rows.push_back(idle_row());
    rows.push_back(handoff_row(base_lin, 1'b0, 1'b0, 1'b0, 2'b00));
    rows.push_back(idle_row());
    rows.push_back(handoff_row(base_lin + 32'd4, 1'b1, 1'b0, 1'b0, 2'b00));
    rows.push_back(handoff_row(base_lin + 32'd6, 1'b0, 1'b1, 1'b0, 2'b00));
    rows.push_back(handoff_row(base_lin + 32'd6, 1'b0, 1'b0, 1'b0, 2'b00));
    rows.push_back(handoff_row(base_lin + 32'd10, 1'b1, 1'b0, 1'b0, 2'b00));
    rows.push_back(handoff_row(base_ptr, 1'b1, 1'b0, 1'b1, 2'b00));
    rows.push_back(handoff_row(base_ptr + 32'd2, 1'b0, 1'b0, 1'b0, 2'b00));
    // Trap redirect in an idle cycle exempts the next handoff
    r = idle_row();
    r.pc_set = 1'b1;
    r.mux = PC_TRAP;
    rows.push_back(r);
    rows.push_back(handoff_row(base_redir, 1'b0, 1'b0, 1'b0, 2'b00));
    rows.push_back(handoff_row(base_redir + 32'd4, 1'b0, 1'b0, 1'b0, 2'b00));
    // Redirect in the handoff cycle itself exempts that handoff
    r = handoff_row(base_redir + 32'h40, 1'b0, 1'b0, 1'b0, 2'b00);
    r.pc_set = 1'b1;
    r.mux = PC_TRAP;
    rows.push_back(r);
    rows.push_back(handoff_row(base_redir + 32'h44, 1'b0, 1'b0, 1'b0, 2'b00));
    // Step of 8 after a full-size instruction
    rows.push_back(handoff_row(base_redir + 32'h4C, 1'b0, 1'b0, 1'b0, 2'b01));
    rows.push_back(idle_row());
    seg_end[0] = rows.size();
    // Same wrong step and a target change with hardening off
    rows.push_back(handoff_row(base_off, 1'b0, 1'b0, 1'b0, 2'b00));
    rows.push_back(handoff_row(base_off + 32'd8, 1'b0, 1'b0, 1'b0, 2'b00));
    rows.push_back(idle_row());
    add_redirect(PC_JUMP, tgt_a, tgt_a ^ 32'h10, 1'b0, 1'b0, 1'b0, 1'b0, 2'b00);
    seg_end[1] = rows.size();
    // Target double checks
    add_redirect(PC_JUMP, tgt_a, tgt_a, 1'b0, 1'b0, 1'b0, 1'b0, 2'b00);
    add_redirect(PC_JUMP, tgt_a, tgt_a ^ 32'h10, 1'b0, 1'b0, 1'b0, 1'b0, 2'b10);
    add_redirect(PC_MRET, tgt_b, tgt_b, 1'b0, 1'b0, 1'b0, 1'b0, 2'b00);
    add_redirect(PC_MRET, tgt_b, tgt_b + 32'd4, 1'b0, 1'b0, 1'b0, 1'b0, 2'b10);
    add_redirect(PC_BRANCH, tgt_a, tgt_a, 1'b1, 1'b1, 1'b0, 1'b0, 2'b00);
    add_redirect(PC_BRANCH, tgt_a, tgt_a + 32'd8, 1'b1, 1'b1, 1'b0, 1'b0, 2'b10);
    // Kill or halt in the second cycle drops the check
    add_redirect(PC_JUMP, tgt_b, tgt_b ^ 32'h4, 1'b0, 1'b0, 1'b1, 1'b0, 2'b00);
    add_redirect(PC_JUMP, tgt_b, tgt_b ^ 32'h4, 1'b0, 1'b0, 1'b0, 1'b1, 2'b00);
    add_redirect(PC_BRANCH, tgt_b, tgt_b + 32'd8, 1'b0, 1'b0, 1'b1, 1'b0, 2'b00);
    add_redirect(PC_BRANCH, tgt_b, tgt_b + 32'd8, 1'b0, 1'b0, 1'b0, 1'b1, 2'b00);
    // Decision flip with data-dependent timing
    add_redirect(PC_BRANCH, tgt_a, tgt_a, 1'b1, 1'b0, 1'b0, 1'b0, 2'b10);
    seg_end[2] = rows.size();
    // Data-independent timing ignores the decision but not the target
    add_redirect(PC_BRANCH, tgt_a, tgt_a, 1'b1, 1'b0, 1'b0, 1'b0, 2'b00);
    add_redirect(PC_BRANCH, tgt_b, tgt_b + 32'd8, 1'b0, 1'b0, 1'b0, 1'b0, 2'b10);
    seg_end[3] = rows.size();
    cycle_limit = rows.size() + 4 * WB_ACCESSES + 20;

    repeat (2) @(posedge clk_i);
    rst_n <= 1'b1;
    // Reset values
    wb_access(1'b0, REG_CTRL, 32'h1);
    wb_access(1'b0, REG_STATUS, 32'h0);
    wb_access(1'b0, REG_FAULT_CNT, 32'h0);
    apply_rows(0, seg_end[0]);
    wb_access(1'b0, REG_STATUS, {30'h0, model_status});
    wb_access(1'b0, REG_FAULT_CNT, {16'h0, model_cnt});
    wb_access(1'b1, REG_CTRL, 32'h0);
    apply_rows(seg_end[0], seg_end[1]);
    wb_access(1'b1, REG_CTRL, 32'h1);
    apply_rows(seg_end[1], seg_end[2]);
    wb_access(1'b0, REG_STATUS, {30'h0, model_status});
    wb_access(1'b0, REG_FAULT_CNT, {16'h0, model_cnt});
    wb_access(1'b1, REG_CTRL, 32'h3);
    apply_rows(seg_end[2], seg_end[3]);
    wb_access(1'b1, REG_CTRL, 32'h1);
    // Write-1 clear of both sticky bits with the counter unchanged
    wb_access(1'b1, REG_STATUS, 32'h3);
    model_status = 2'b00;
    wb_access(1'b0, REG_STATUS, 32'h0);
    wb_access(1'b0, REG_FAULT_CNT, {16'h0, model_cnt});
    $display("all tests passed");
    $finish;
  end

endmodule

// ==== sim.f ====
pc_harden_pkg.sv
pc_seq_check.sv
pc_target_check.sv
pc_alert_csr.sv
pc_harden_top.sv
tb_pc_harden.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator; a $fatal gives a failing exit status
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sim.f --top-module tb_pc_harden -o tb_pc_harden
./obj_dir/tb_pc_harden
